// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_core_top
RTL_TOP   ?= cpu_core_top
FILELIST  ?= cpu_core_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== cpu_core_top.f ====
isa_pkg.sv
mem_pkg.sv
cpu_ifs.sv
instr_decode.sv
reg_file_control.sv
register_file.sv
execute_stage.sv
data_memory.sv
cpu_core_top.sv
tb_cpu_core_top.sv

// ==== cpu_core_top.sv ====
`timescale 1ns/10ps

module cpu_core_top #(
   parameter int DMEM_DEPTH = mem_pkg::DMEM_DEPTH_DEFAULT
) (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          instr_valid_i,
   input  logic [isa_pkg::INSTR_W-1:0]   instr_i,

   output logic                          wb_valid_o,
   output logic [isa_pkg::REG_IDX_W-1:0] wb_addr_o,
   output logic [isa_pkg::XLEN-1:0]      wb_data_o,
   output logic                          jump_valid_o,
   output logic                          jump_taken_o,
   output logic [isa_pkg::XLEN-1:0]      jump_target_o
);

   logic [isa_pkg::INSTR_TYPE_W-1:0] decode_instruction_type;
   logic [isa_pkg::ALU_OP_W-1:0]     dec_alu_op;
   logic [isa_pkg::REG_IDX_W-1:0]    dec_rd;
   logic [isa_pkg::REG_IDX_W-1:0]    dec_rs0;
   logic [isa_pkg::REG_IDX_W-1:0]    dec_rs1;
   logic [isa_pkg::XLEN-1:0]         dec_imm;

   logic [isa_pkg::INSTR_TYPE_W-1:0] write_back_instruction_type;
   logic [isa_pkg::REG_IDX_W-1:0]    wb_rd;
   logic [isa_pkg::XLEN-1:0]         wb_data;

   rf_read_if rf_rd ();
   dmem_if #(.ADDR_W($clog2(DMEM_DEPTH))) dmem ();

   instr_decode u_instr_decode (
      .clk_i                     (clk_i),
      .arst_n_i                  (arst_n_i),
      .instr_valid_i             (instr_valid_i),
      .instr_i                   (instr_i),
      .decode_instruction_type_o (decode_instruction_type),
      .alu_op_o                  (dec_alu_op),
      .rd_o                      (dec_rd),
      .rs0_o                     (dec_rs0),
      .rs1_o                     (dec_rs1),
      .imm_o                     (dec_imm)
   );

   // the control block write port is also the wb port of the core
   reg_file_control u_reg_file_control (
      .decode_instruction_type_i     (decode_instruction_type),
      .rs0_i                         (dec_rs0),
      .rs1_i                         (dec_rs1),
      .write_back_instruction_type_i (write_back_instruction_type),
      .wb_rd_i                       (wb_rd),
      .wb_data_i                     (wb_data),
      .write_address_o               (wb_addr_o),
      .write_data_o                  (wb_data_o),
      .write_enable_o                (wb_valid_o),
      .rf_rd                         (rf_rd.addr)
   );

   register_file u_register_file (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .write_address_i (wb_addr_o),
      .write_data_i    (wb_data_o),
      .write_enable_i  (wb_valid_o),
      .rf_rd           (rf_rd.regs)
   );

   execute_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_execute_stage (
      .clk_i                         (clk_i),
      .arst_n_i                      (arst_n_i),
      .decode_instruction_type_i     (decode_instruction_type),
      .alu_op_i                      (dec_alu_op),
      .rd_i                          (dec_rd),
      .imm_i                         (dec_imm),
      .rf_rd                         (rf_rd.operands),
      .dmem                          (dmem.master),
      .write_back_instruction_type_o (write_back_instruction_type),
      .wb_rd_o                       (wb_rd),
      .wb_data_o                     (wb_data),
      .jump_valid_o                  (jump_valid_o),
      .jump_taken_o                  (jump_taken_o),
      .jump_target_o                 (jump_target_o)
   );

   data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) u_data_memory (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .dmem     (dmem.mem)
   );

endmodule

// ==== cpu_ifs.sv ====
`timescale 1ns/10ps

// register file read ports, addresses from the control block
interface rf_read_if;

   logic [isa_pkg::REG_IDX_W-1:0] raddr0;
   logic [isa_pkg::REG_IDX_W-1:0] raddr1;
   logic [isa_pkg::XLEN-1:0]      rdata0;
   logic [isa_pkg::XLEN-1:0]      rdata1;

   modport addr (
      output raddr0,
      output raddr1
   );

   modport regs (
      input  raddr0,
      input  raddr1,
      output rdata0,
      output rdata1
   );

   // execute stage samples both operands
   modport operands (
      input rdata0,
      input rdata1
   );

endinterface

// data memory access, word index only
interface dmem_if #(
   parameter int ADDR_W = $clog2(mem_pkg::DMEM_DEPTH_DEFAULT)
);

   logic [ADDR_W-1:0]               addr;
   logic [mem_pkg::DMEM_WORD_W-1:0] wdata;
   logic                            we;
   logic [mem_pkg::DMEM_WORD_W-1:0] rdata;

   modport master (
      output addr,
      output wdata,
      output we,
      input  rdata
   );

   modport mem (
      input  addr,
      input  wdata,
      input  we,
      output rdata
   );

endinterface

// ==== data_memory.sv ====
`timescale 1ns/10ps

module data_memory #(
   parameter int DMEM_DEPTH = mem_pkg::DMEM_DEPTH_DEFAULT
) (
   input logic clk_i,
   input logic arst_n_i,

   dmem_if.mem dmem
);

   logic [mem_pkg::DMEM_WORD_W-1:0] mem_q [DMEM_DEPTH];

   // whole array clears on reset, writes on we
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            mem_q[i] <= '0;
         end
      end else if (dmem.we) begin
         mem_q[dmem.addr] <= dmem.wdata;
      end
   end

   // asynchronous read
   assign dmem.rdata = mem_q[dmem.addr];

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage #(
   parameter int DMEM_DEPTH = mem_pkg::DMEM_DEPTH_DEFAULT
) (
   input  logic                             clk_i,
   input  logic                             arst_n_i,

   // decode fields
   input  logic [isa_pkg::INSTR_TYPE_W-1:0] decode_instruction_type_i,
   input  logic [isa_pkg::ALU_OP_W-1:0]     alu_op_i,
   input  logic [isa_pkg::REG_IDX_W-1:0]    rd_i,
   input  logic [isa_pkg::XLEN-1:0]         imm_i,

   rf_read_if.operands                      rf_rd,
   dmem_if.master                           dmem,

   // write-back stage, towards the control block
   output logic [isa_pkg::INSTR_TYPE_W-1:0] write_back_instruction_type_o,
   output logic [isa_pkg::REG_IDX_W-1:0]    wb_rd_o,
   output logic [isa_pkg::XLEN-1:0]         wb_data_o,

   output logic                             jump_valid_o,
   output logic                             jump_taken_o,
   output logic [isa_pkg::XLEN-1:0]         jump_target_o
);

   localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);
   localparam int SHAMT_W     = $clog2(isa_pkg::XLEN);

   logic [isa_pkg::INSTR_TYPE_W-1:0] ex_type_q;
   logic [isa_pkg::ALU_OP_W-1:0]     ex_alu_op_q;
   logic [isa_pkg::REG_IDX_W-1:0]    ex_rd_q;
   logic [isa_pkg::XLEN-1:0]         ex_imm_q;
   logic [isa_pkg::XLEN-1:0]         ex_op0_q;
   logic [isa_pkg::XLEN-1:0]         ex_op1_q;

   logic [isa_pkg::XLEN-1:0]         alu_result;
   logic [isa_pkg::XLEN-1:0]         ex_result;
   logic                             ex_is_store;
   logic                             ex_is_jump;

   logic [isa_pkg::INSTR_TYPE_W-1:0] wb_type_q;
   logic [isa_pkg::REG_IDX_W-1:0]    wb_rd_q;
   logic [isa_pkg::XLEN-1:0]         wb_data_q;

   // stage types reset to nop, payload follows them
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ex_type_q <= isa_pkg::INSTR_NOP;
         wb_type_q <= isa_pkg::INSTR_NOP;
      end else begin
         ex_type_q <= decode_instruction_type_i;
         wb_type_q <= ex_type_q;
      end
   end

   always_ff @(posedge clk_i) begin
      ex_alu_op_q <= alu_op_i;
      ex_rd_q     <= rd_i;
      ex_imm_q    <= imm_i;
      ex_op0_q    <= rf_rd.rdata0;
      ex_op1_q    <= rf_rd.rdata1;
      wb_rd_q     <= ex_rd_q;
      wb_data_q   <= ex_result;
   end

   // alu
   always_comb begin
      case (ex_alu_op_q)
         isa_pkg::ALU_ADD: alu_result = ex_op0_q + ex_op1_q;
         isa_pkg::ALU_SUB: alu_result = ex_op0_q - ex_op1_q;
         isa_pkg::ALU_AND: alu_result = ex_op0_q & ex_op1_q;
         isa_pkg::ALU_OR:  alu_result = ex_op0_q | ex_op1_q;
         isa_pkg::ALU_XOR: alu_result = ex_op0_q ^ ex_op1_q;
         isa_pkg::ALU_SLL: alu_result = ex_op0_q << ex_op1_q[SHAMT_W-1:0];
         isa_pkg::ALU_SRL: alu_result = ex_op0_q >> ex_op1_q[SHAMT_W-1:0];
         isa_pkg::ALU_SLT: begin
            alu_result    = '0;
            alu_result[0] = $signed(ex_op0_q) < $signed(ex_op1_q);
         end
         default:          alu_result = '0;
      endcase
   end

   // memory, store addresses through operand 1, load through operand 0
   assign ex_is_store = ex_type_q == isa_pkg::INSTR_STORE;
   assign dmem.we     = ex_is_store;
   assign dmem.wdata  = ex_op0_q;
   assign dmem.addr   = ex_is_store ? ex_op1_q[DMEM_ADDR_W-1:0] : ex_op0_q[DMEM_ADDR_W-1:0];

   // jumps are only reported
   assign ex_is_jump    = ex_type_q == isa_pkg::INSTR_JUMP;
   assign jump_valid_o  = ex_is_jump;
   assign jump_taken_o  = ex_is_jump && (ex_op0_q != '0);
   assign jump_target_o = ex_op1_q;

   // result for the write-back register
   always_comb begin
      case (ex_type_q)
         isa_pkg::INSTR_ALU_OP:         ex_result = alu_result;
         isa_pkg::INSTR_LOAD_IMMEDIATE: ex_result = ex_imm_q;
         isa_pkg::INSTR_LOAD:           ex_result = dmem.rdata;
         default:                       ex_result = '0;
      endcase
   end

   assign write_back_instruction_type_o = wb_type_q;
   assign wb_rd_o                       = wb_rd_q;
   assign wb_data_o                     = wb_data_q;

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic                             instr_valid_i,
   input  isa_pkg::instr_u                  instr_i,

   output logic [isa_pkg::INSTR_TYPE_W-1:0] decode_instruction_type_o,
   output logic [isa_pkg::ALU_OP_W-1:0]     alu_op_o,
   output logic [isa_pkg::REG_IDX_W-1:0]    rd_o,
   output logic [isa_pkg::REG_IDX_W-1:0]    rs0_o,
   output logic [isa_pkg::REG_IDX_W-1:0]    rs1_o,
   output logic [isa_pkg::XLEN-1:0]         imm_o
);

   localparam int SIGN_EXT_W = isa_pkg::XLEN - isa_pkg::IMM_W;

   isa_pkg::instr_u instr_q;
   logic            imm_sign;

   // decode register, a missing strobe loads a nop
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         instr_q <= '0;
      end else if (instr_valid_i) begin
         instr_q <= instr_i;
      end else begin
         instr_q <= '0;
      end
   end

   // register view
   assign decode_instruction_type_o = instr_q.r.instr_type;
   assign alu_op_o                  = instr_q.r.alu_op;
   assign rd_o                      = instr_q.r.rd;
   assign rs0_o                     = instr_q.r.rs0;
   assign rs1_o                     = instr_q.r.rs1;

   // immediate view, sign extended to the word width
   assign imm_sign = instr_q.i.imm22[isa_pkg::IMM_W-1];
   assign imm_o    = {{SIGN_EXT_W{imm_sign}}, instr_q.i.imm22};

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

   // word and field widths
   localparam int XLEN         = 32;
   localparam int INSTR_W      = 32;
   localparam int REG_IDX_W    = 5;
   localparam int NUM_REGS     = 32;
   localparam int INSTR_TYPE_W = 5;
   localparam int ALU_OP_W     = 4;
   localparam int IMM_W        = 22;

   // instruction types, held in bits 31..27
   localparam logic [INSTR_TYPE_W-1:0] INSTR_NOP            = 5'd0;
   localparam logic [INSTR_TYPE_W-1:0] INSTR_ALU_OP         = 5'd1;
   localparam logic [INSTR_TYPE_W-1:0] INSTR_LOAD_IMMEDIATE = 5'd2;
   localparam logic [INSTR_TYPE_W-1:0] INSTR_LOAD           = 5'd3;
   localparam logic [INSTR_TYPE_W-1:0] INSTR_STORE          = 5'd4;
   localparam logic [INSTR_TYPE_W-1:0] INSTR_JUMP           = 5'd5;

   // alu operations
   localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
   localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
   localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd3;
   localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
   localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd5;
   localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd6;
   // signed compare
   localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd7;

   // one instruction word, two views of its low bits
   typedef union packed {
      struct packed {
         logic [INSTR_TYPE_W-1:0] instr_type;
         logic [REG_IDX_W-1:0]    rd;
         logic [REG_IDX_W-1:0]    rs0;
         logic [REG_IDX_W-1:0]    rs1;
         logic [ALU_OP_W-1:0]     alu_op;
         logic [7:0]              unused;
      } r;
      struct packed {
         logic [INSTR_TYPE_W-1:0] instr_type;
         logic [REG_IDX_W-1:0]    rd;
         logic [IMM_W-1:0]        imm22;
      } i;
   } instr_u;

endpackage

// ==== mem_pkg.sv ====
package mem_pkg;

   // default number of data memory words, must stay a power of two
   localparam int DMEM_DEPTH_DEFAULT = 64;

   // one memory word holds one register value
   localparam int DMEM_WORD_W = isa_pkg::XLEN;

   // the memory index is the low bits of the address register value,
   // so addresses above the depth wrap around

endpackage

// ==== reg_file_control.sv ====
`timescale 1ns/10ps

module reg_file_control (
   input  logic [isa_pkg::INSTR_TYPE_W-1:0] decode_instruction_type_i,
   input  logic [isa_pkg::REG_IDX_W-1:0]    rs0_i,
   input  logic [isa_pkg::REG_IDX_W-1:0]    rs1_i,

   input  logic [isa_pkg::INSTR_TYPE_W-1:0] write_back_instruction_type_i,
   input  logic [isa_pkg::REG_IDX_W-1:0]    wb_rd_i,
   input  logic [isa_pkg::XLEN-1:0]         wb_data_i,

   // write port of the register file
   output logic [isa_pkg::REG_IDX_W-1:0]    write_address_o,
   output logic [isa_pkg::XLEN-1:0]         write_data_o,
   output logic                             write_enable_o,

   rf_read_if.addr                          rf_rd
);

   logic wb_is_alu_instr;
   logic wb_is_load_imm_instr;
   logic wb_is_load_instr;

   // read addresses follow the decode stage type
   always_comb begin
      case (decode_instruction_type_i)
         isa_pkg::INSTR_LOAD: begin
            // address register only
            rf_rd.raddr0 = rs0_i;
            rf_rd.raddr1 = '0;
         end
         isa_pkg::INSTR_ALU_OP,
         isa_pkg::INSTR_STORE,
         isa_pkg::INSTR_JUMP: begin
            // store: data and address, jump: condition and target
            rf_rd.raddr0 = rs0_i;
            rf_rd.raddr1 = rs1_i;
         end
         default: begin
            rf_rd.raddr0 = '0;
            rf_rd.raddr1 = '0;
         end
      endcase
   end

   // write side follows the write-back stage type
   assign wb_is_alu_instr      = write_back_instruction_type_i == isa_pkg::INSTR_ALU_OP;
   assign wb_is_load_imm_instr =
      write_back_instruction_type_i == isa_pkg::INSTR_LOAD_IMMEDIATE;
   assign wb_is_load_instr     = write_back_instruction_type_i == isa_pkg::INSTR_LOAD;

   // store, jump and nop leave the registers alone
   assign write_enable_o  = wb_is_alu_instr || wb_is_load_imm_instr || wb_is_load_instr;
   assign write_address_o = wb_rd_i;
   assign write_data_o    = wb_data_i;

endmodule

// ==== register_file.sv ====
`timescale 1ns/10ps

module register_file (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic [isa_pkg::REG_IDX_W-1:0] write_address_i,
   input  logic [isa_pkg::XLEN-1:0]      write_data_i,
   input  logic                          write_enable_i,

   rf_read_if.regs                       rf_rd
);

   logic [isa_pkg::XLEN-1:0] regs_q [isa_pkg::NUM_REGS];

   // every register is writable, no hardwired zero
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (write_enable_i) begin
         regs_q[write_address_i] <= write_data_i;
      end
   end

   // same cycle write is seen on the read ports
   assign rf_rd.rdata0 = (write_enable_i && (write_address_i == rf_rd.raddr0)) ?
                         write_data_i : regs_q[rf_rd.raddr0];
   assign rf_rd.rdata1 = (write_enable_i && (write_address_i == rf_rd.raddr1)) ?
                         write_data_i : regs_q[rf_rd.raddr1];

endmodule

// ==== tb_cpu_core_top.sv ====
`timescale 1ns/10ps

module tb_cpu_core_top;

   localparam int CLK_PERIOD    = 20;
   localparam int TB_DMEM_DEPTH = 16;
   localparam int TB_ADDR_W     = $clog2(TB_DMEM_DEPTH);
   localparam int NUM_INSTR     = 60;
   localparam int WATCHDOG_NS   = NUM_INSTR * 4 * CLK_PERIOD + 16 * CLK_PERIOD + 2000;

   logic                          clk_i;
   logic                          arst_n_i;
   logic                          instr_valid_i;
   logic [isa_pkg::INSTR_W-1:0]   instr_i;
   logic                          wb_valid_o;
   logic [isa_pkg::REG_IDX_W-1:0] wb_addr_o;
   logic [isa_pkg::XLEN-1:0]      wb_data_o;
   logic                          jump_valid_o;
   logic                          jump_taken_o;
   logic [isa_pkg::XLEN-1:0]      jump_target_o;

   // reference model state
   logic [isa_pkg::XLEN-1:0] model_regs [isa_pkg::NUM_REGS];
   logic [isa_pkg::XLEN-1:0] model_mem  [TB_DMEM_DEPTH];

   // expected results, tagged with the negedge count where they are due
   int                            wb_due_q     [$];
   logic [isa_pkg::REG_IDX_W-1:0] wb_addr_q    [$];
   logic [isa_pkg::XLEN-1:0]      wb_data_q    [$];
   int                            jmp_due_q    [$];
   logic                          jmp_taken_q  [$];
   logic [isa_pkg::XLEN-1:0]      jmp_target_q [$];

   int    errors  = 0;
   int    cyc_cnt = 0;
   int    seed;
   string cur_test = "none";

   cpu_core_top #(.DMEM_DEPTH(TB_DMEM_DEPTH)) dut_i (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .wb_valid_o    (wb_valid_o),
      .wb_addr_o     (wb_addr_o),
      .wb_data_o     (wb_data_o),
      .jump_valid_o  (jump_valid_o),
      .jump_taken_o  (jump_taken_o),
      .jump_target_o (jump_target_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   task automatic check_word(input string what, input logic [isa_pkg::XLEN-1:0] exp_val,
                             input logic [isa_pkg::XLEN-1:0] act_val);
      if (act_val !== exp_val) begin
         $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
         errors++;
      end
   endtask

   task automatic check_reg_idx(input string what,
                                input logic [isa_pkg::REG_IDX_W-1:0] exp_val,
                                input logic [isa_pkg::REG_IDX_W-1:0] act_val);
      if (act_val !== exp_val) begin
         $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp_val, act_val);
         errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp_val, input logic act_val);
      if (act_val !== exp_val) begin
         $display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp_val, act_val);
         errors++;
      end
   endtask

   function automatic logic [isa_pkg::XLEN-1:0] rand_word();
      return $random(seed);
   endfunction

   function automatic int rand_idx();
      logic [isa_pkg::XLEN-1:0] w;
      w = rand_word();
      return {27'd0, w[4:0]};
   endfunction

   function automatic isa_pkg::instr_u make_reg_instr(
      input logic [isa_pkg::INSTR_TYPE_W-1:0] t, input int rd, input int rs0,
      input int rs1, input logic [isa_pkg::ALU_OP_W-1:0] op);
      isa_pkg::instr_u w;
      w              = '0;
      w.r.instr_type = t;
      w.r.rd         = rd[4:0];
      w.r.rs0        = rs0[4:0];
      w.r.rs1        = rs1[4:0];
      w.r.alu_op     = op;
      return w;
   endfunction

   function automatic isa_pkg::instr_u make_imm_instr(
      input logic [isa_pkg::INSTR_TYPE_W-1:0] t, input int rd, input int imm);
      isa_pkg::instr_u w;
      w              = '0;
      w.i.instr_type = t;
      w.i.rd         = rd[4:0];
      w.i.imm22      = imm[21:0];
      return w;
   endfunction

   // expected alu result, shifts take the low 5 bits of b
   function automatic logic [isa_pkg::XLEN-1:0] alu_ref(
      input logic [isa_pkg::ALU_OP_W-1:0] op, input logic [isa_pkg::XLEN-1:0] a,
      input logic [isa_pkg::XLEN-1:0] b);
      case (op)
         isa_pkg::ALU_ADD: return a + b;
         isa_pkg::ALU_SUB: return a - b;
         isa_pkg::ALU_AND: return a & b;
         isa_pkg::ALU_OR:  return a | b;
         isa_pkg::ALU_XOR: return a ^ b;
         isa_pkg::ALU_SLL: return a << b[4:0];
         isa_pkg::ALU_SRL: return a >> b[4:0];
         isa_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default:          return '0;
      endcase
   endfunction

   // issue one instruction and queue what it should produce
   task automatic send(input isa_pkg::instr_u w);
      logic [isa_pkg::XLEN-1:0] a;
      logic [isa_pkg::XLEN-1:0] b;
      logic [isa_pkg::XLEN-1:0] res;
      @(posedge clk_i);
      a   = model_regs[w.r.rs0];
      b   = model_regs[w.r.rs1];
      res = '0;
      case (w.r.instr_type)
         isa_pkg::INSTR_ALU_OP: res = alu_ref(w.r.alu_op, a, b);
         isa_pkg::INSTR_LOAD_IMMEDIATE:
            res = {{(isa_pkg::XLEN - isa_pkg::IMM_W){w.i.imm22[isa_pkg::IMM_W-1]}},
                   w.i.imm22};
         isa_pkg::INSTR_LOAD:  res = model_mem[a[TB_ADDR_W-1:0]];
         isa_pkg::INSTR_STORE: model_mem[b[TB_ADDR_W-1:0]] = a;
         isa_pkg::INSTR_JUMP: begin
            jmp_due_q.push_back(cyc_cnt + 3);
            jmp_taken_q.push_back(a != '0);
            jmp_target_q.push_back(b);
         end
         default: ;
      endcase
      if (w.r.instr_type inside {isa_pkg::INSTR_ALU_OP, isa_pkg::INSTR_LOAD_IMMEDIATE,
                                 isa_pkg::INSTR_LOAD}) begin
         model_regs[w.r.rd] = res;
         wb_due_q.push_back(cyc_cnt + 4);
         wb_addr_q.push_back(w.r.rd);
         wb_data_q.push_back(res);
      end
      instr_valid_i <= 1'b1;
      instr_i       <= w;
   endtask

   // strobe low, with junk on the instruction bus
   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk_i);
         instr_valid_i <= 1'b0;
         instr_i       <= rand_word();
      end
   endtask

   task automatic check_wb_port();
      if (wb_valid_o === 1'b1) begin
         if (wb_due_q.size() == 0) begin
            $display("ERROR in %s: write-back to r%0d that no instruction should make",
                     cur_test, wb_addr_o);
            errors++;
         end else begin
            if (wb_due_q[0] != cyc_cnt) begin
               $display("ERROR in %s: write-back came %0d cycles off its slot",
                        cur_test, cyc_cnt - wb_due_q[0]);
               errors++;
            end
            check_reg_idx("wb_addr_o", wb_addr_q.pop_front(), wb_addr_o);
            check_word("wb_data_o", wb_data_q.pop_front(), wb_data_o);
            wb_due_q.delete(0);
         end
      end else if (wb_due_q.size() != 0 && wb_due_q[0] <= cyc_cnt) begin
         $display("ERROR in %s: write-back to r%0d never appeared", cur_test, wb_addr_q[0]);
         errors++;
         wb_due_q.delete(0);
         wb_addr_q.delete(0);
         wb_data_q.delete(0);
      end
   endtask

   task automatic check_jump_port();
      if (jump_valid_o === 1'b1) begin
         if (jmp_due_q.size() == 0) begin
            $display("ERROR in %s: jump reported with no jump in flight", cur_test);
            errors++;
         end else begin
            if (jmp_due_q[0] != cyc_cnt) begin
               $display("ERROR in %s: jump came %0d cycles off its slot",
                        cur_test, cyc_cnt - jmp_due_q[0]);
               errors++;
            end
            check_bit("jump_taken_o", jmp_taken_q.pop_front(), jump_taken_o);
            check_word("jump_target_o", jmp_target_q.pop_front(), jump_target_o);
            jmp_due_q.delete(0);
         end
      end else if (jmp_due_q.size() != 0 && jmp_due_q[0] <= cyc_cnt) begin
         $display("ERROR in %s: expected jump was never reported", cur_test);
         errors++;
         jmp_due_q.delete(0);
         jmp_taken_q.delete(0);
         jmp_target_q.delete(0);
      end
   endtask

   // outputs are stable at the falling edge
   initial begin
      forever begin
         @(negedge clk_i);
         cyc_cnt++;
         check_wb_port();
         check_jump_port();
      end
   end

   task automatic reset_state_test();
      cur_test = "reset_state";
      // any valid during reset is flagged by the monitor
      repeat (16) @(posedge clk_i);
      arst_n_i <= 1'b1;
      idle(2);
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 3, rand_word()));
      idle(1);
      send(make_reg_instr(isa_pkg::INSTR_LOAD, 4, 3, 0, isa_pkg::ALU_ADD));
      send(make_reg_instr(isa_pkg::INSTR_ALU_OP, 5, 20, 21, isa_pkg::ALU_ADD));
      idle(4);
   endtask

   task automatic load_imm_test();
      cur_test = "load_immediate";
      for (int k = 0; k < 8; k++) begin
         send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, rand_idx(), rand_word()));
      end
      idle(4);
   endtask

   task automatic alu_test();
      logic [isa_pkg::ALU_OP_W-1:0] op;
      cur_test = "alu_ops";
      for (int k = 1; k <= 8; k++) begin
         send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, k, rand_word()));
      end
      // minus one against one for the signed compare
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 30, -1));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 31, 1));
      idle(1);
      // op 8 is undefined and gives zero
      for (int k = 0; k < 9; k++) begin
         op = k[3:0];
         send(make_reg_instr(isa_pkg::INSTR_ALU_OP, 10 + k, 1 + k % 8, 1 + (k + 3) % 8, op));
      end
      send(make_reg_instr(isa_pkg::INSTR_ALU_OP, 20, 30, 31, isa_pkg::ALU_SLT));
      send(make_reg_instr(isa_pkg::INSTR_ALU_OP, 21, 31, 30, isa_pkg::ALU_SLT));
      send(make_reg_instr(isa_pkg::INSTR_ALU_OP, 22, 1, 2, isa_pkg::ALU_SUB));
      idle(1);
      send(make_reg_instr(isa_pkg::INSTR_ALU_OP, 23, 22, 3, isa_pkg::ALU_XOR));
      idle(4);
   endtask

   task automatic store_load_test();
      cur_test = "store_load";
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 1, 3));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 2, 19));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 3, 7));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 4, rand_word()));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 5, rand_word()));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 6, 23));
      idle(1);
      send(make_reg_instr(isa_pkg::INSTR_STORE, 0, 4, 3, isa_pkg::ALU_ADD));
      // address 19 lands on word 3
      send(make_reg_instr(isa_pkg::INSTR_STORE, 0, 5, 2, isa_pkg::ALU_ADD));
      send(make_reg_instr(isa_pkg::INSTR_LOAD, 7, 1, 0, isa_pkg::ALU_ADD));
      send(make_reg_instr(isa_pkg::INSTR_LOAD, 8, 6, 0, isa_pkg::ALU_ADD));
      send(make_reg_instr(isa_pkg::INSTR_LOAD, 9, 3, 0, isa_pkg::ALU_ADD));
      idle(4);
   endtask

   task automatic jump_test();
      cur_test = "jumps";
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 1, 0));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 2, rand_word()));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 3, 5));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 4, -8));
      idle(1);
      send(make_reg_instr(isa_pkg::INSTR_JUMP, 0, 1, 2, isa_pkg::ALU_ADD));
      send(make_reg_instr(isa_pkg::INSTR_JUMP, 0, 3, 2, isa_pkg::ALU_ADD));
      send(make_reg_instr(isa_pkg::INSTR_JUMP, 0, 4, 3, isa_pkg::ALU_ADD));
      idle(4);
   endtask

   task automatic pipeline_test();
      cur_test = "pipelining";
      for (int k = 0; k < 4; k++) begin
         send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 11 + k, rand_word()));
      end
      send(make_reg_instr(isa_pkg::INSTR_NOP, 1, 2, 3, isa_pkg::ALU_ADD));
      idle(2);
      send(make_reg_instr(5'd17, 1, 2, 3, isa_pkg::ALU_ADD));
      send(make_imm_instr(isa_pkg::INSTR_LOAD_IMMEDIATE, 15, rand_word()));
      idle(1);
      // reads r15 in the cycle it is written
      send(make_reg_instr(isa_pkg::INSTR_ALU_OP, 16, 15, 15, isa_pkg::ALU_ADD));
      idle(4);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired, the run did not finish in time");
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      seed          = 32'h31bc;
      arst_n_i      <= 1'b0;
      instr_valid_i <= 1'b0;
      instr_i       <= '0;
      for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      for (int i = 0; i < TB_DMEM_DEPTH; i++) begin
         model_mem[i] = '0;
      end
      reset_state_test();
      load_imm_test();
      alu_test();
      store_load_test();
      jump_test();
      pipeline_test();
      idle(6);
      if (wb_due_q.size() != 0 || jmp_due_q.size() != 0) begin
         $display("ERROR: results still pending at the end of the run");
         errors++;
      end
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
